// ==== bench/asic_model.svh ====
`ifndef ASIC_MODEL_SVH
`define ASIC_MODEL_SVH

////////////////////////////////////////////////////////////
// Raster position from cycles since reset
////////////////////////////////////////////////////////////
function automatic int hpos(input int cyc);
    return cyc % `H_TOTAL;
endfunction

function automatic int vpos(input int cyc);
    return (cyc / `H_TOTAL) % `V_TOTAL;
endfunction

function automatic logic want_vint_n(input int hc, input int vc);
    return !((vc == `V_SYNC_START) && (hc < `H_FETCH_START));
endfunction

// Line interrupt only fires on visible lines
function automatic logic want_rint_n(input int hc, input int vc, input int lint);
    return !((lint < `V_ACTIVE) && (vc == lint) && (hc < `H_FETCH_START));
endfunction

// Hsync polarity flips on the vsync lines
function automatic logic want_csync(input int hc, input int vc);
    logic hs;
    logic vs;
    hs = (hc >= `H_RBORDER + `H_FPORCH) && (hc < `H_RBORDER + `H_FPORCH + `H_SYNC);
    vs = (vc >= `V_SYNC_START) && (vc < `V_SYNC_START + `V_SYNC);
    return !(hs ^ vs);
endfunction

function automatic logic want_contend(input int hc, input int vc, input int mode,
                                      input logic soff);
    logic fetch;
    int   nib;
    fetch = (vc < `V_ACTIVE) && (hc >= `H_FETCH_START) && !soff;
    nib = hc % 16;
    if (fetch && nib < 10) return 1'b1;
    if (!fetch && (nib == 0 || nib == 1 || nib == 8 || nib == 9)) return 1'b1;
    if (mode == 0 && nib < 10 && (hc < 128 || hc >= `H_FETCH_START)) return 1'b1;
    return 1'b0;
endfunction

////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////
function automatic logic want_rom(input logic [15:0] addr, input logic [7:0] lmpr);
    return (addr[15:14] == 2'd0 && !lmpr[5]) || (addr[15:14] == 2'd3 && lmpr[6]);
endfunction

// External memory claims sections 2 and 3
function automatic logic want_ramcs_n(input logic [15:0] addr, input logic [7:0] lmpr,
                                      input logic [7:0] hmpr);
    return want_rom(addr, lmpr) || (addr[15] && hmpr[7]);
endfunction

function automatic logic want_ramwr_n(input logic [15:0] addr, input logic [7:0] lmpr,
                                      input logic wr_n_in, input logic cs_n);
    return cs_n || wr_n_in || (addr[15:14] == 2'd0 && lmpr[7]);
endfunction

function automatic logic [18:0] want_ram_addr(input logic [15:0] addr,
                                              input logic [7:0] lmpr,
                                              input logic [7:0] hmpr);
    logic [4:0] page;
    case (addr[15:14])
        2'd0:    page = lmpr[4:0];
        2'd1:    page = lmpr[4:0] + 5'd1;
        2'd2:    page = hmpr[4:0];
        default: page = hmpr[4:0] + 5'd1;
    endcase
    return {page, addr[13:0]};
endfunction

`endif

// ==== bench/tb_asic.sv ====
`timescale 1ns/1ps
`include "asic_settings.svh"

module tb_asic;

    localparam logic [7:0] P_STATUS = 8'(`PORT_LINEINT_STATUS);
    localparam logic [7:0] P_LMPR   = 8'(`PORT_LMPR);
    localparam logic [7:0] P_HMPR   = 8'(`PORT_HMPR);
    localparam logic [7:0] P_VMPR   = 8'(`PORT_VMPR);
    localparam logic [7:0] P_BORDER = 8'(`PORT_BORDER);
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

    logic        clk;
    logic        rst_n;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        ear;
    logic [7:0]  keyboard;
    logic [15:0] cpuaddr;
    logic [7:0]  data_from_cpu;
    logic [7:0]  data_to_cpu;
    logic        data_enable_n;
    logic        wait_n;
    logic [18:0] cpuramaddr;
    logic        romcs_n;
    logic        ramcs_n;
    logic        ramwr_n;
    logic        mic;
    logic        beep;
    logic        disc1_n;
    logic        disc2_n;
    logic        csync;
    logic        int_n;

    logic [31:0] lcg_state;
    int          cyc;
    // Mirror of the port registers
    logic [7:0]  m_lmpr;
    logic [7:0]  m_hmpr;
    logic [7:0]  m_vmpr;
    logic [7:0]  m_border;
    logic [7:0]  m_lint;

    `include "asic_model.svh"

    asic_top u_asic_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycles since reset give hc and vc
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        assert (got === want) else begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("Test FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test FAILED");
        $fatal(1, "timeout");
    endtask

    // One bus cycle with outputs sampled mid-cycle
    task automatic cpu_cycle(input logic mreq, input logic iorq, input logic rd,
                             input logic wr, input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        mreq_n        <= mreq;
        iorq_n        <= iorq;
        rd_n          <= rd;
        wr_n          <= wr;
        cpuaddr       <= addr;
        data_from_cpu <= data;
        @(negedge clk);
    endtask

    task automatic port_write(input logic [7:0] port, input logic [7:0] data);
        logic [31:0] r;
        r = next_rand();
        cpu_cycle(1'b1, 1'b0, 1'b1, 1'b0, {r[7:0], port}, data);
        // Register latches on this edge
        cpu_cycle(1'b1, 1'b1, 1'b1, 1'b1, {r[7:0], port}, data);
        case (port)
            P_STATUS: m_lint   = data;
            P_LMPR:   m_lmpr   = data;
            P_HMPR:   m_hmpr   = data;
            P_VMPR:   m_vmpr   = data;
            P_BORDER: m_border = data;
            default: ;
        endcase
    endtask

    task automatic check_mem_map(input logic [15:0] addr, input logic wr);
        logic rom;
        logic cs_n;
        rom = want_rom(addr, m_lmpr);
        cs_n = want_ramcs_n(addr, m_lmpr, m_hmpr);
        expect_value(32'(romcs_n), 32'(!rom), "romcs_n");
        expect_value(32'(ramcs_n), 32'(cs_n), "ramcs_n");
        expect_value(32'(ramwr_n), 32'(want_ramwr_n(addr, m_lmpr, !wr, cs_n)), "ramwr_n");
        expect_value(32'(cpuramaddr), 32'(want_ram_addr(addr, m_lmpr, m_hmpr)), "cpuramaddr");
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        logic [7:0]  port;
        logic [7:0]  status;
        logic        wr;
        logic        first;
        logic        is_io;
        logic        c;
        logic        rom;
        int          hc;
        int          vc;
        int          n;
        int          i;
        int          gap;
        lcg_state = 32'd64;
        rst_n = 1'b0;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        ear = 1'b0;
        keyboard = 8'hff;
        cpuaddr = 16'h0000;
        data_from_cpu = 8'h00;
        m_lmpr = 8'h00;
        m_hmpr = 8'h00;
        m_vmpr = 8'h00;
        m_border = 8'h00;
        m_lint = 8'hff;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        ////////////////////////////////////////////////////////////
        // Register readback
        ////////////////////////////////////////////////////////////
        for (i = 0; i < 3; i++) begin
            port = P_LMPR + 8'(i);
            cpu_cycle(1'b1, 1'b0, 1'b0, 1'b1, {8'h00, port}, 8'h00);
            expect_value(32'(data_to_cpu), 32'h0, "paging register after reset");
            expect_value(32'(data_enable_n), 32'h0, "data_enable_n");
        end
        for (i = 0; i < 24; i++) begin
            r = next_rand();
            port = P_LMPR + 8'(int'(r[9:8]) % 3);
            port_write(port, r[23:16]);
            cpu_cycle(1'b1, 1'b0, 1'b0, 1'b1, {r[31:24], port}, 8'h00);
            expect_value(32'(data_to_cpu), 32'(r[23:16]), "register readback");
            expect_value(32'(data_enable_n), 32'h0, "data_enable_n");
        end

        ////////////////////////////////////////////////////////////
        // Memory map
        ////////////////////////////////////////////////////////////
        for (i = 0; i < 40; i++) begin
            r = next_rand();
            port_write(P_LMPR, r[7:0]);
            port_write(P_HMPR, r[15:8]);
            repeat (8) begin
                r = next_rand();
                wr = r[16];
                cpu_cycle(1'b0, 1'b1, wr, !wr, r[15:0], r[31:24]);
                check_mem_map(r[15:0], wr);
            end
        end

        ////////////////////////////////////////////////////////////
        // Frame timing with the status read held for a whole frame
        ////////////////////////////////////////////////////////////
        r = next_rand();
        port_write(P_STATUS, 8'(r % 32'd192));
        @(posedge clk);
        keyboard <= r[31:24];
        cpu_cycle(1'b1, 1'b0, 1'b0, 1'b1, {8'h00, P_STATUS}, 8'h00);
        expect_value(32'(data_enable_n), 32'h0, "data_enable_n on status");
        n = 0;
        while (hpos(cyc) != 0 || vpos(cyc) != 0) begin
            if (n > FRAME_CYCLES) begin
                timeout_fail("the start of a frame");
            end
            @(negedge clk);
            n++;
        end
        for (i = 0; i < FRAME_CYCLES; i++) begin
            hc = hpos(cyc);
            vc = vpos(cyc);
            status = {keyboard[7:5], 1'b1, want_vint_n(hc, vc), 2'b11,
                      want_rint_n(hc, vc, int'(m_lint))};
            expect_value(32'(int_n), 32'(status[3] & status[0]), "int_n");
            expect_value(32'(csync), 32'(want_csync(hc, vc)), "csync");
            expect_value(32'(data_to_cpu), 32'(status), "status read");
            @(negedge clk);
        end

        ////////////////////////////////////////////////////////////
        // Contention
        ////////////////////////////////////////////////////////////
        for (i = 0; i < 300; i++) begin
            r = next_rand();
            case (r[3:0])
                4'd0: port_write(P_VMPR, r[15:8]);
                4'd1: port_write(P_BORDER, r[15:8]);
                4'd2: port_write(P_LMPR, r[15:8]);
                default: ;
            endcase
            gap = int'(r[25:16]);
            repeat (gap) cpu_cycle(1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 8'h00);
            r = next_rand();
            addr = r[15:0];
            is_io = r[16];
            wr = r[17];
            // Keep I/O writes away from the register ports
            if (is_io && addr[7:0] >= P_STATUS && addr[7:0] <= P_BORDER) begin
                addr[7:0] = addr[7:0] ^ 8'h10;
            end
            cpu_cycle(is_io, !is_io, wr, !wr, addr, r[31:24]);
            hc = hpos(cyc);
            vc = vpos(cyc);
            c = want_contend(hc, vc, int'(m_vmpr[6:5]), m_border[7] & m_vmpr[6]);
            if (is_io) begin
                expect_value(32'(wait_n), 32'(!c), "wait_n on I/O access");
            end else begin
                rom = want_rom(addr, m_lmpr);
                expect_value(32'(wait_n), 32'(!(c && !rom)), "wait_n on memory access");
            end
        end

        ////////////////////////////////////////////////////////////
        // Border port and disk selects
        ////////////////////////////////////////////////////////////
        for (i = 0; i < 30; i++) begin
            r = next_rand();
            if (r[0]) begin
                port_write(P_VMPR, r[15:8]);
            end
            port_write(P_BORDER, r[23:16]);
            expect_value(32'(mic), 32'(m_border[3]), "mic");
            expect_value(32'(beep), 32'(m_border[4]), "beep");
            @(posedge clk);
            ear <= r[1];
            keyboard <= r[31:24];
            cpu_cycle(1'b1, 1'b0, 1'b0, 1'b1, {r[15:8], P_BORDER}, 8'h00);
            status = {m_border[7] & m_vmpr[6], ear, 1'b0, keyboard[4:0]};
            expect_value(32'(data_to_cpu), 32'(status), "border port read");
            expect_value(32'(data_enable_n), 32'h0, "data_enable_n on border read");
            first = r[2];
            port = first ? 8'(`DISC1_LO) + 8'(r[5:3]) : 8'(`DISC2_LO) + 8'(r[5:3]);
            cpu_cycle(1'b1, 1'b0, 1'b0, 1'b1, {r[15:8], port}, 8'h00);
            expect_value(32'(disc1_n), 32'(!first), "disc1_n");
            expect_value(32'(disc2_n), 32'(first), "disc2_n");
            expect_value(32'(data_enable_n), 32'h1, "data_enable_n on disk read");
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== hw/asic_ifs.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Paging state from the port registers to the mapper
////////////////////////////////////////////////////////////
interface paging_if;
    logic [4:0] low_page;
    logic [4:0] high_page;
    logic       rom_a;
    logic       rom_d;
    logic       write_protect_a;
    logic       external_mem;

    modport regs (
        output low_page,
        output high_page,
        output rom_a,
        output rom_d,
        output write_protect_a,
        output external_mem
    );

    modport mapper (
        input low_page,
        input high_page,
        input rom_a,
        input rom_d,
        input write_protect_a,
        input external_mem
    );
endinterface

////////////////////////////////////////////////////////////
// Raster results for wait generation and status reads
////////////////////////////////////////////////////////////
interface raster_if;
    logic mem_contention;
    logic io_contention;
    logic vint_n;
    logic rint_n;

    modport timer (
        output mem_contention,
        output io_contention,
        output vint_n,
        output rint_n
    );

    modport arbiter (input mem_contention, input io_contention);
    modport status (input vint_n, input rint_n);
endinterface

// ==== hw/asic_pkg.sv ====
package asic_pkg;

    // Memory view of the CPU address
    typedef struct packed {
        logic [1:0]  section;
        logic [13:0] offset;
    } cpu_mem_addr_t;

    // I/O view, port number in the low byte
    typedef struct packed {
        logic [7:0] high;
        logic [7:0] port;
    } cpu_io_addr_t;

    // Same 16-bit word, decoded per cycle type
    typedef union packed {
        cpu_mem_addr_t mem;
        cpu_io_addr_t  io;
    } cpu_addr_u;

endpackage

// ==== hw/asic_settings.svh ====
`ifndef ASIC_SETTINGS_SVH
`define ASIC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Line geometry, in pixel clocks
////////////////////////////////////////////////////////////
`define H_ACTIVE    512
`define H_RBORDER   64
`define H_FPORCH    16
`define H_SYNC      64
`define H_BPORCH    64
`define H_LBORDER   48
`define H_TOTAL     (`H_ACTIVE + `H_RBORDER + `H_FPORCH + `H_SYNC + `H_BPORCH + `H_LBORDER)

////////////////////////////////////////////////////////////
// Frame geometry, in lines
////////////////////////////////////////////////////////////
`define V_ACTIVE    192
`define V_BBORDER   48
`define V_FPORCH    4
`define V_SYNC      4
`define V_BPORCH    16
`define V_TBORDER   48
`define V_TOTAL     (`V_ACTIVE + `V_BBORDER + `V_FPORCH + `V_SYNC + `V_BPORCH + `V_TBORDER)

// First vsync line, also the frame interrupt line
`define V_SYNC_START    244
// Start of pixel fetch, also the interrupt pulse length
`define H_FETCH_START   256

// Counter widths
`define HC_W    10
`define VC_W    9

////////////////////////////////////////////////////////////
// I/O port numbers
////////////////////////////////////////////////////////////
`define PORT_LINEINT_STATUS 249
`define PORT_LMPR           250
`define PORT_HMPR           251
`define PORT_VMPR           252
`define PORT_BORDER         254

// Disk controller port ranges
`define DISC1_LO    224
`define DISC1_HI    231
`define DISC2_LO    240
`define DISC2_HI    247

// CPU address sections, 16 KB each
`define SECTION_A   0
`define SECTION_B   1
`define SECTION_C   2
`define SECTION_D   3

`define PAGE_W      5
`define RAM_ADDR_W  19

`endif

// ==== hw/asic_top.sv ====
`timescale 1ns/1ps

module asic_top import asic_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        ear,
    input  logic [7:0]  keyboard,
    input  logic [15:0] cpuaddr,
    input  logic [7:0]  data_from_cpu,
    output logic [7:0]  data_to_cpu,
    output logic        data_enable_n,
    output logic        wait_n,
    output logic [18:0] cpuramaddr,
    output logic        romcs_n,
    output logic        ramcs_n,
    output logic        ramwr_n,
    output logic        mic,
    output logic        beep,
    output logic        disc1_n,
    output logic        disc2_n,
    output logic        csync,
    output logic        int_n
);

    logic [1:0] screen_mode;
    logic       screen_off;
    logic [7:0] line_int;
    logic       rom_selected;

    paging_if pif ();
    raster_if rif ();

    ////////////////////////////////////////////////////////////
    // Port registers
    ////////////////////////////////////////////////////////////
    io_ports u_io_ports (
        .clk           (clk),
        .rst_n         (rst_n),
        .iorq_n        (iorq_n),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .ear           (ear),
        .cpu_addr      (cpu_addr_u'(cpuaddr)),
        .data_from_cpu (data_from_cpu),
        .keyboard      (keyboard),
        .pif           (pif.regs),
        .rif           (rif.status),
        .screen_mode   (screen_mode),
        .screen_off    (screen_off),
        .line_int      (line_int),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n),
        .mic           (mic),
        .beep          (beep),
        .disc1_n       (disc1_n),
        .disc2_n       (disc2_n)
    );

    raster_timing u_raster_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .screen_off  (screen_off),
        .screen_mode (screen_mode),
        .line_int    (line_int),
        .rif         (rif.timer),
        .csync       (csync)
    );

    ////////////////////////////////////////////////////////////
    // CPU memory side
    ////////////////////////////////////////////////////////////
    memory_mapper u_memory_mapper (
        .mreq_n       (mreq_n),
        .wr_n         (wr_n),
        .cpu_addr     (cpu_addr_u'(cpuaddr)),
        .pif          (pif.mapper),
        .romcs_n      (romcs_n),
        .ramcs_n      (ramcs_n),
        .ramwr_n      (ramwr_n),
        .cpuramaddr   (cpuramaddr),
        .rom_selected (rom_selected)
    );

    wait_arbiter u_wait_arbiter (
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .rom_selected (rom_selected),
        .rif          (rif.arbiter),
        .wait_n       (wait_n)
    );

    assign int_n = rif.vint_n & rif.rint_n;

endmodule

// ==== hw/io_ports.sv ====
`timescale 1ns/1ps
`include "asic_settings.svh"

module io_ports import asic_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         iorq_n,
    input  logic         rd_n,
    input  logic         wr_n,
    input  logic         ear,
    input  cpu_addr_u    cpu_addr,
    input  logic [7:0]   data_from_cpu,
    input  logic [7:0]   keyboard,
    paging_if.regs       pif,
    raster_if.status     rif,
    output logic [1:0]   screen_mode,
    output logic         screen_off,
    output logic [7:0]   line_int,
    output logic [7:0]   data_to_cpu,
    output logic         data_enable_n,
    output logic         mic,
    output logic         beep,
    output logic         disc1_n,
    output logic         disc2_n
);

    localparam logic [7:0] P_STATUS = 8'(`PORT_LINEINT_STATUS);
    localparam logic [7:0] P_LMPR   = 8'(`PORT_LMPR);
    localparam logic [7:0] P_HMPR   = 8'(`PORT_HMPR);
    localparam logic [7:0] P_VMPR   = 8'(`PORT_VMPR);
    localparam logic [7:0] P_BORDER = 8'(`PORT_BORDER);
    localparam logic [7:0] D1_LO    = 8'(`DISC1_LO);
    localparam logic [7:0] D1_HI    = 8'(`DISC1_HI);
    localparam logic [7:0] D2_LO    = 8'(`DISC2_LO);
    localparam logic [7:0] D2_HI    = 8'(`DISC2_HI);

    logic [7:0] vmpr;
    logic [7:0] lmpr;
    logic [7:0] hmpr;
    logic [7:0] border;
    logic [7:0] port;
    logic       io_wr;
    logic       io_rd;

    assign port  = cpu_addr.io.port;
    assign io_wr = ~iorq_n & ~wr_n;
    assign io_rd = ~iorq_n & ~rd_n;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vmpr     <= 8'h00;
            lmpr     <= 8'h00;
            hmpr     <= 8'h00;
            border   <= 8'h00;
            line_int <= 8'hff;
        end else if (io_wr) begin
            case (port)
                P_BORDER: border   <= data_from_cpu;
                P_VMPR:   vmpr     <= data_from_cpu;
                P_HMPR:   hmpr     <= data_from_cpu;
                P_LMPR:   lmpr     <= data_from_cpu;
                P_STATUS: line_int <= data_from_cpu;
                default: ;
            endcase
        end
    end

    // LMPR bit 5 low keeps ROM in section A
    assign pif.low_page        = lmpr[4:0];
    assign pif.rom_a           = ~lmpr[5];
    assign pif.rom_d           = lmpr[6];
    assign pif.write_protect_a = lmpr[7];
    assign pif.high_page       = hmpr[4:0];
    assign pif.external_mem    = hmpr[7];

    assign screen_mode = vmpr[6:5];
    // Screen blanking only exists in modes 3 and 4
    assign screen_off  = border[7] & vmpr[6];
    assign mic         = border[3];
    assign beep        = border[4];

    ////////////////////////////////////////////////////////////
    // Port reads and disk selects
    ////////////////////////////////////////////////////////////
    always_comb begin
        data_to_cpu   = 8'hff;
        data_enable_n = 1'b1;
        disc1_n       = 1'b1;
        disc2_n       = 1'b1;
        if (io_rd) begin
            data_enable_n = 1'b0;
            case (port)
                P_BORDER: data_to_cpu = {screen_off, ear, 1'b0, keyboard[4:0]};
                P_STATUS: data_to_cpu = {keyboard[7:5], 1'b1, rif.vint_n, 2'b11, rif.rint_n};
                P_VMPR:   data_to_cpu = vmpr;
                P_HMPR:   data_to_cpu = hmpr;
                P_LMPR:   data_to_cpu = lmpr;
                default: begin
                    // Disk controller drives the bus itself
                    data_enable_n = 1'b1;
                    if (port >= D1_LO && port <= D1_HI) begin
                        disc1_n = 1'b0;
                    end else if (port >= D2_LO && port <= D2_HI) begin
                        disc2_n = 1'b0;
                    end
                end
            endcase
        end
    end

    a_one_disc: assert property (@(posedge clk) disable iff (!rst_n)
        !(!disc1_n && !disc2_n));

endmodule

// ==== hw/memory_mapper.sv ====
`timescale 1ns/1ps
`include "asic_settings.svh"

module memory_mapper import asic_pkg::*; (
    input  logic                    mreq_n,
    input  logic                    wr_n,
    input  cpu_addr_u               cpu_addr,
    paging_if.mapper                pif,
    output logic                    romcs_n,
    output logic                    ramcs_n,
    output logic                    ramwr_n,
    output logic [`RAM_ADDR_W-1:0]  cpuramaddr,
    output logic                    rom_selected
);

    localparam logic [1:0] SEC_A = 2'(`SECTION_A);
    localparam logic [1:0] SEC_B = 2'(`SECTION_B);
    localparam logic [1:0] SEC_C = 2'(`SECTION_C);
    localparam logic [1:0] SEC_D = 2'(`SECTION_D);

    logic [1:0]         section;
    logic [`PAGE_W-1:0] page;
    logic               ext_section;

    assign section = cpu_addr.mem.section;

    // ROM overlays section A or D
    assign rom_selected = ~mreq_n & (((section == SEC_A) & pif.rom_a)
                                   | ((section == SEC_D) & pif.rom_d));

    // External memory takes over the upper 32 KB
    assign ext_section = section[1] & pif.external_mem;

    assign romcs_n = ~rom_selected;
    assign ramcs_n = mreq_n | rom_selected | ext_section;

    ////////////////////////////////////////////////////////////
    // Page selection
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (section)
            SEC_A:   page = pif.low_page;
            SEC_B:   page = pif.low_page + 1'b1;
            SEC_C:   page = pif.high_page;
            default: page = pif.high_page + 1'b1;
        endcase
    end

    assign cpuramaddr = {page, cpu_addr.mem.offset};

    assign ramwr_n = ramcs_n | wr_n | ((section == SEC_A) & pif.write_protect_a);

    // Sampled at the end of each memory cycle
    a_one_chip: assert property (@(posedge mreq_n)
        !(!romcs_n && !ramcs_n));

endmodule

// ==== hw/raster_timing.sv ====
`timescale 1ns/1ps
`include "asic_settings.svh"

module raster_timing (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        screen_off,
    input  logic [1:0]  screen_mode,
    input  logic [7:0]  line_int,
    raster_if.timer     rif,
    output logic        csync
);

    localparam logic [`HC_W-1:0] HC_LAST     = `HC_W'(`H_TOTAL - 1);
    localparam logic [`VC_W-1:0] VC_LAST     = `VC_W'(`V_TOTAL - 1);
    localparam logic [`HC_W-1:0] HS_START    = `HC_W'(`H_RBORDER + `H_FPORCH);
    localparam logic [`HC_W-1:0] HS_END      = `HC_W'(`H_RBORDER + `H_FPORCH + `H_SYNC);
    localparam logic [`VC_W-1:0] VS_START    = `VC_W'(`V_SYNC_START);
    localparam logic [`VC_W-1:0] VS_END      = `VC_W'(`V_SYNC_START + `V_SYNC);
    localparam logic [`VC_W-1:0] ACTIVE_END  = `VC_W'(`V_ACTIVE);
    localparam logic [`HC_W-1:0] FETCH_START = `HC_W'(`H_FETCH_START);
    localparam logic [7:0]       RINT_MAX    = 8'(`V_ACTIVE - 1);
    // Mode 1 attribute fetch slots end here
    localparam logic [`HC_W-1:0] MODE1_END   = `HC_W'(128);

    logic [`HC_W-1:0] hc;
    logic [`VC_W-1:0] vc;
    logic             hsync_on;
    logic             vsync_on;
    logic             fetching_pixels;
    logic [3:0]       slot;
    logic             contend;

    ////////////////////////////////////////////////////////////
    // Pixel and line counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (hc == HC_LAST) begin
            hc <= '0;
            if (vc == VC_LAST) begin
                vc <= '0;
            end else begin
                vc <= vc + 1'b1;
            end
        end else begin
            hc <= hc + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sync and interrupts
    ////////////////////////////////////////////////////////////
    assign hsync_on = (hc >= HS_START) && (hc < HS_END);
    assign vsync_on = (vc >= VS_START) && (vc < VS_END);

    // Serrated vsync, hsync polarity flips during the sync lines
    assign csync = ~(hsync_on ^ vsync_on);

    assign rif.vint_n = ~((vc == VS_START) && (hc < FETCH_START));
    assign rif.rint_n = ~((line_int <= RINT_MAX) && (vc == {1'b0, line_int})
                          && (hc < FETCH_START));

    ////////////////////////////////////////////////////////////
    // Contention windows
    ////////////////////////////////////////////////////////////
    assign fetching_pixels = (vc < ACTIVE_END) && (hc >= FETCH_START) && !screen_off;
    assign slot = hc[3:0];

    always_comb begin
        contend = 1'b0;
        if (fetching_pixels && slot < 4'd10) begin
            contend = 1'b1;
        end
        if (!fetching_pixels && (slot == 4'd0 || slot == 4'd1 || slot == 4'd8 || slot == 4'd9)) begin
            contend = 1'b1;
        end
        // Extra slots for the attribute fetch in mode 1
        if (screen_mode == 2'b00 && slot < 4'd10 && (hc < MODE1_END || hc >= FETCH_START)) begin
            contend = 1'b1;
        end
    end

    assign rif.mem_contention = contend;
    assign rif.io_contention  = contend;

    a_counter_range: assert property (@(posedge clk) disable iff (!rst_n)
        (hc <= HC_LAST) && (vc <= VC_LAST));

endmodule

// ==== hw/wait_arbiter.sv ====
`timescale 1ns/1ps

module wait_arbiter (
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        rom_selected,
    raster_if.arbiter   rif,
    output logic        wait_n
);

    logic mem_wait;
    logic io_wait;

    // ROM sits off the video bus and never waits
    assign mem_wait = ~mreq_n & rif.mem_contention & ~rom_selected;

    assign io_wait = ~iorq_n & (~rd_n | ~wr_n) & rif.io_contention;

    assign wait_n = ~(mem_wait | io_wait);

endmodule

// ==== list.f ====
+incdir+hw
+incdir+bench
hw/asic_pkg.sv
hw/asic_ifs.sv
hw/io_ports.sv
hw/raster_timing.sv
hw/memory_mapper.sv
hw/wait_arbiter.sv
hw/asic_top.sv
bench/tb_asic.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status is the test result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f --top-module tb_asic -o tb_asic \
    && ./obj_dir/tb_asic \
    || exit 1
